// File: rtl/ycc_cfg.svh
`ifndef YCC_CFG_SVH
`define YCC_CFG_SVH

// sample and pixel widths
`define YCC_SAMPLE_W 16
`define PIX_W 8

// bank depths, y holds four blocks in 4:2:0
`define Y_WORDS 256
`define C_WORDS 64

`define PIX_FIFO_DEPTH 2

// colour coefficients scaled by 2^K_FRAC
`define K_CR_R 5742
`define K_CB_G 1409
`define K_CR_G 2925
`define K_CB_B 7258
`define K_FRAC 12

`endif

// File: rtl/ycc_pkg.sv
`include "ycc_cfg.svh"

package ycc_pkg;

	typedef logic signed [`YCC_SAMPLE_W-1:0] sample_t;

	// one block row, col[0] is the leftmost sample
	typedef struct packed {
		sample_t [7:0] col;
	} ycc_row_t;

	typedef struct packed {
		logic [2:0] blk;
		logic [2:0] row;
		ycc_row_t   data;
	} blk_wr_t;

	typedef enum logic {
		FMT_444,
		FMT_420
	} mcu_fmt_t;

	typedef struct packed {
		logic [3:0] row;
		logic [3:0] col;
	} pix_pos_t;

	// raster index, or its 16x16 position in 4:2:0
	typedef union packed {
		logic [7:0] lin;
		pix_pos_t   pos;
	} pix_idx_u;

	typedef struct packed {
		sample_t y;
		sample_t cb;
		sample_t cr;
	} ycc_pix_t;

	typedef struct packed {
		logic [`PIX_W-1:0] r;
		logic [`PIX_W-1:0] g;
		logic [`PIX_W-1:0] b;
		logic [7:0]        idx;
	} rgb_pix_t;

endpackage

// File: rtl/mcu_out_fsm.sv
`timescale 1ns/100ps

module mcu_out_fsm
	import ycc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     mcu_done,
	input  mcu_fmt_t mcu_fmt,
	input  logic     last,
	input  logic     fifo_full,
	output logic     ycc_ready,
	output logic     rd_bank,
	output mcu_fmt_t rd_fmt,
	output logic     step
);

	typedef enum logic {
		IDLE,
		DRAIN
	} state_t;

	state_t state;
	logic   wr_full;
	logic   bank_full;
	logic   rd_free;
	logic   swap;

	assign step = (state == DRAIN) && !fifo_full;

	// mcu_done already counts on the edge that registers it
	assign bank_full = wr_full || mcu_done;
	// read side frees up on the final step of a drain
	assign rd_free = (state == IDLE) || (step && last);
	assign swap = bank_full && rd_free;

	assign ycc_ready = !wr_full;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			wr_full <= 1'b0;
			rd_bank <= 1'b0;
			rd_fmt  <= FMT_444;
		end else begin
			wr_full <= bank_full && !swap;
			if (swap) begin
				state   <= DRAIN;
				rd_bank <= !rd_bank;
				rd_fmt  <= mcu_fmt;
			end else if (step && last) begin
				state <= IDLE;
			end
		end
	end

	//----------------------------------------------------------
	// upstream must wait for a free write bank
	assert property (@(posedge clk) disable iff (rst) mcu_done |-> ycc_ready);

	// the counter rests at 0 between drains
	assert property (@(posedge clk) disable iff (rst) state == IDLE |-> !last);

endmodule

// File: rtl/pix_counter.sv
`timescale 1ns/100ps

module pix_counter
	import ycc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     step,
	input  mcu_fmt_t rd_fmt,
	output pix_idx_u idx,
	output logic     last
);

	logic [7:0] last_idx;

	assign last_idx = (rd_fmt == FMT_420) ? 8'd255 : 8'd63;
	assign last = idx.lin == last_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			idx.lin <= 8'd0;
		end else if (step) begin
			if (last)
				idx.lin <= 8'd0;
			else
				idx.lin <= idx.lin + 8'd1;
		end
	end

	// format only changes at a swap, when the count sits at 0
	assert property (@(posedge clk) disable iff (rst)
		rd_fmt == FMT_444 |-> idx.lin <= 8'd63);

endmodule

// File: rtl/ycc_pingpong_buf.sv
`timescale 1ns/100ps
`include "ycc_cfg.svh"

module ycc_pingpong_buf
	import ycc_pkg::*;
(
	input  logic     clk,
	input  logic     blk_we,
	input  blk_wr_t  blk_wr,
	input  mcu_fmt_t mcu_fmt,
	input  logic     rd_bank,
	input  mcu_fmt_t rd_fmt,
	input  pix_idx_u idx,
	output ycc_pix_t ycc
);

	sample_t y_mem  [2][`Y_WORDS];
	sample_t cb_mem [2][`C_WORDS];
	sample_t cr_mem [2][`C_WORDS];

	logic       wr_bank;
	logic       y_sel;
	logic       cb_sel;
	logic       cr_sel;
	logic [4:0] y_hi;
	logic [5:0] c_rd;

	//----------------------------------------------------------
	// write side
	assign wr_bank = !rd_bank;

	always_comb begin
		if (mcu_fmt == FMT_420) begin
			y_sel  = !blk_wr.blk[2];
			cb_sel = blk_wr.blk == 3'd4;
			cr_sel = blk_wr.blk == 3'd5;
			// quadrant bits become the row and column msbs
			y_hi   = {blk_wr.blk[1], blk_wr.row, blk_wr.blk[0]};
		end else begin
			y_sel  = blk_wr.blk == 3'd0;
			cb_sel = blk_wr.blk == 3'd1;
			cr_sel = blk_wr.blk == 3'd2;
			y_hi   = {2'b00, blk_wr.row};
		end
	end

	always_ff @(posedge clk) begin
		if (blk_we) begin
			for (int c = 0; c < 8; c++) begin
				if (y_sel)
					y_mem[wr_bank][{y_hi, 3'(c)}] <= blk_wr.data.col[c];
				if (cb_sel)
					cb_mem[wr_bank][{blk_wr.row, 3'(c)}] <= blk_wr.data.col[c];
				if (cr_sel)
					cr_mem[wr_bank][{blk_wr.row, 3'(c)}] <= blk_wr.data.col[c];
			end
		end
	end

	//----------------------------------------------------------
	// read side
	always_comb begin
		// 2x2 chroma replication
		if (rd_fmt == FMT_420)
			c_rd = {idx.pos.row[3:1], idx.pos.col[3:1]};
		else
			c_rd = idx.lin[5:0];
		ycc.y  = y_mem[rd_bank][idx.lin];
		ycc.cb = cb_mem[rd_bank][c_rd];
		ycc.cr = cr_mem[rd_bank][c_rd];
	end

endmodule

// File: rtl/ycc_to_rgb.sv
`timescale 1ns/100ps
`include "ycc_cfg.svh"

module ycc_to_rgb
	import ycc_pkg::*;
(
	input  ycc_pix_t          ycc,
	output logic [`PIX_W-1:0] r,
	output logic [`PIX_W-1:0] g,
	output logic [`PIX_W-1:0] b
);

	// coefficients fit in K_BITS
	localparam int K_BITS = 14;
	localparam int P_W = `YCC_SAMPLE_W + K_BITS;
	localparam int S_W = P_W - `K_FRAC + 2;

	typedef logic signed [P_W-1:0] prod_t;
	typedef logic signed [S_W-1:0] sum_t;

	// constant multiply as a sum of shifted samples
	function automatic prod_t mul_k(sample_t x, int unsigned k);
		prod_t xe;
		prod_t acc;
		xe = x;
		acc = '0;
		for (int i = 0; i < K_BITS; i++) begin
			if (k[i])
				acc = acc + (xe <<< i);
		end
		return acc;
	endfunction

	function automatic logic [`PIX_W-1:0] clamp(sum_t v);
		if (v < 0)
			return '0;
		else if (v > 255)
			return '1;
		else
			return v[`PIX_W-1:0];
	endfunction

	sum_t cr_r;
	sum_t cb_g;
	sum_t cr_g;
	sum_t cb_b;
	sum_t base;

	// arithmetic shift gives floor
	assign cr_r = sum_t'(mul_k(ycc.cr, `K_CR_R) >>> `K_FRAC);
	assign cb_g = sum_t'(mul_k(ycc.cb, `K_CB_G) >>> `K_FRAC);
	assign cr_g = sum_t'(mul_k(ycc.cr, `K_CR_G) >>> `K_FRAC);
	assign cb_b = sum_t'(mul_k(ycc.cb, `K_CB_B) >>> `K_FRAC);

	assign base = sum_t'(ycc.y) + sum_t'(128);

	assign r = clamp(base + cr_r);
	assign g = clamp(base - cb_g - cr_g);
	assign b = clamp(base + cb_b);

endmodule

// File: rtl/pix_fifo.sv
`timescale 1ns/100ps
`include "ycc_cfg.svh"

module pix_fifo
	import ycc_pkg::*;
#(
	parameter int DEPTH = `PIX_FIFO_DEPTH
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr,
	input  rgb_pix_t din,
	input  logic     rd,
	output rgb_pix_t dout,
	output logic     full,
	output logic     empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	rgb_pix_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          wr_en;
	logic          rd_en;

	function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = count == '0;
	assign full = count == CW'(DEPTH);
	assign rd_en = rd && !empty;
	// a full fifo still takes a write while the head leaves
	assign wr_en = wr && (!full || rd);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	assert property (@(posedge clk) disable iff (rst) wr && full |-> rd);
	assert property (@(posedge clk) disable iff (rst) rd |-> !empty);

endmodule

// File: rtl/ycc_rgb_top.sv
`timescale 1ns/100ps
`include "ycc_cfg.svh"

module ycc_rgb_top
	import ycc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     blk_we,
	input  blk_wr_t  blk_wr,
	input  mcu_fmt_t mcu_fmt,
	input  logic     mcu_done,
	input  logic     pix_next,
	output logic     ycc_ready,
	output logic     pix_valid,
	output rgb_pix_t pix
);

	logic              rd_bank;
	mcu_fmt_t          rd_fmt;
	logic              step;
	pix_idx_u          idx;
	logic              last;
	ycc_pix_t          ycc;
	logic [`PIX_W-1:0] pix_r;
	logic [`PIX_W-1:0] pix_g;
	logic [`PIX_W-1:0] pix_b;
	rgb_pix_t          fifo_din;
	logic              fifo_full;
	logic              fifo_empty;

	mcu_out_fsm mcu_out_fsm_i (
		.clk       (clk),
		.rst       (rst),
		.mcu_done  (mcu_done),
		.mcu_fmt   (mcu_fmt),
		.last      (last),
		.fifo_full (fifo_full),
		.ycc_ready (ycc_ready),
		.rd_bank   (rd_bank),
		.rd_fmt    (rd_fmt),
		.step      (step)
	);

	pix_counter pix_counter_i (
		.clk    (clk),
		.rst    (rst),
		.step   (step),
		.rd_fmt (rd_fmt),
		.idx    (idx),
		.last   (last)
	);

	ycc_pingpong_buf ycc_pingpong_buf_i (
		.clk     (clk),
		.blk_we  (blk_we),
		.blk_wr  (blk_wr),
		.mcu_fmt (mcu_fmt),
		.rd_bank (rd_bank),
		.rd_fmt  (rd_fmt),
		.idx     (idx),
		.ycc     (ycc)
	);

	ycc_to_rgb ycc_to_rgb_i (
		.ycc (ycc),
		.r   (pix_r),
		.g   (pix_g),
		.b   (pix_b)
	);

	// pixel index travels with its colour
	assign fifo_din = '{r: pix_r, g: pix_g, b: pix_b, idx: idx.lin};

	pix_fifo pix_fifo_i (
		.clk   (clk),
		.rst   (rst),
		.wr    (step),
		.din   (fifo_din),
		.rd    (pix_next),
		.dout  (pix),
		.full  (fifo_full),
		.empty (fifo_empty)
	);

	assign pix_valid = !fifo_empty;

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held over 8 rising edges
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

// File: tests/tb_ycc_rgb.sv
`timescale 1ns/100ps
`include "ycc_cfg.svh"

// 8 mcus of 256 pixels at up to 4 cycles each, plus margin
`define TIMEOUT_CYCLES (8 * 256 * 4 + 1000)

module tb_ycc_rgb
	import ycc_pkg::*;
();

	typedef enum {SRC_RANDOM, SRC_EXTREME, SRC_REPLAY} src_t;

	logic     clk;
	logic     rst;
	logic     blk_we;
	blk_wr_t  blk_wr;
	mcu_fmt_t mcu_fmt;
	logic     mcu_done;
	logic     pix_next = 1'b0;
	logic     ycc_ready;
	logic     pix_valid;
	rgb_pix_t pix;

	int       seed = 32'h965a_599e;
	int       sink_seed = 32'h965a_599e;
	int       cycles = 0;
	int       pop_count = 0;
	int       base;
	logic     bp_on = 1'b0;
	logic     pop_now;
	sample_t  m_y [`Y_WORDS];
	sample_t  m_cb [`C_WORDS];
	sample_t  m_cr [`C_WORDS];
	rgb_pix_t exp_q [$];

	tb_clk_gen clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	ycc_rgb_top ycc_rgb_top_i (
		.clk       (clk),
		.rst       (rst),
		.blk_we    (blk_we),
		.blk_wr    (blk_wr),
		.mcu_fmt   (mcu_fmt),
		.mcu_done  (mcu_done),
		.pix_next  (pix_next),
		.ycc_ready (ycc_ready),
		.pix_valid (pix_valid),
		.pix       (pix)
	);

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_pix(input rgb_pix_t got, input rgb_pix_t exp);
		if (got !== exp)
			abort_run($sformatf({"error at time %0t: pixel idx %0d rgb %0d %0d %0d, ",
				"expected idx %0d rgb %0d %0d %0d"}, $time, got.idx, got.r, got.g,
				got.b, exp.idx, exp.r, exp.g, exp.b));
	endtask

	task automatic check_ready(input string what, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	//------------------------------------------------------------
	// reference model
	function automatic logic [7:0] clamp8(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return 8'(v);
	endfunction

	function automatic rgb_pix_t ref_pixel(input mcu_fmt_t fmt, input int idx);
		int ci;
		int y;
		int cb;
		int cr;
		rgb_pix_t p;
		// chroma shared by each 2x2 square in 4:2:0
		ci = (fmt == FMT_420) ? (idx / 32) * 8 + (idx % 16) / 2 : idx;
		y = int'(m_y[idx]);
		cb = int'(m_cb[ci]);
		cr = int'(m_cr[ci]);
		p.r = clamp8(y + 128 + ((cr * `K_CR_R) >>> `K_FRAC));
		p.g = clamp8(y + 128 - ((cb * `K_CB_G) >>> `K_FRAC) - ((cr * `K_CR_G) >>> `K_FRAC));
		p.b = clamp8(y + 128 + ((cb * `K_CB_B) >>> `K_FRAC));
		p.idx = 8'(idx);
		return p;
	endfunction

	task automatic queue_ref(input mcu_fmt_t fmt);
		int n;
		n = (fmt == FMT_420) ? 256 : 64;
		for (int i = 0; i < n; i++)
			exp_q.push_back(ref_pixel(fmt, i));
	endtask

	//------------------------------------------------------------
	// upstream side
	function automatic sample_t new_sample(input src_t src);
		int r;
		r = $random(seed);
		if (src == SRC_EXTREME)
			return r[0] ? 16'sd1023 : -16'sd1023;
		return sample_t'(signed'(r[10:0]));
	endfunction

	task automatic load_mcu(input mcu_fmt_t fmt, input src_t src);
		int nblk;
		int pos;
		logic is_y;
		blk_wr_t w;
		nblk = (fmt == FMT_420) ? 6 : 3;
		for (int b = 0; b < nblk; b++) begin
			for (int row = 0; row < 8; row++) begin
				w.blk = 3'(b);
				w.row = 3'(row);
				is_y = b < nblk - 2;
				for (int c = 0; c < 8; c++) begin
					// quadrant bit 1 picks the vertical half, bit 0 the horizontal
					if (is_y && fmt == FMT_420)
						pos = ((b / 2) * 8 + row) * 16 + (b % 2) * 8 + c;
					else
						pos = row * 8 + c;
					if (src != SRC_REPLAY) begin
						if (is_y)
							m_y[pos] = new_sample(src);
						else if (b == nblk - 2)
							m_cb[pos] = new_sample(src);
						else
							m_cr[pos] = new_sample(src);
					end
					if (is_y)
						w.data.col[c] = m_y[pos];
					else if (b == nblk - 2)
						w.data.col[c] = m_cb[pos];
					else
						w.data.col[c] = m_cr[pos];
				end
				while (!ycc_ready)
					tick();
				blk_we = 1'b1;
				blk_wr = w;
				mcu_fmt = fmt;
				tick();
				blk_we = 1'b0;
			end
		end
	endtask

	task automatic pulse_done();
		while (!ycc_ready)
			tick();
		mcu_done = 1'b1;
		tick();
		mcu_done = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			tick();
	endtask

	//------------------------------------------------------------
	// sink that pops and compares against the expected queue
	always @(posedge clk) begin
		#2;
		pop_now = 1'b0;
		if (rst === 1'b0 && pix_valid)
			pop_now = !bp_on || ($unsigned($random(sink_seed)) % 3 == 0);
		if (pop_now) begin
			if (exp_q.size() == 0)
				abort_run("a pixel came out when no pixel was expected");
			check_pix(pix, exp_q.pop_front());
			pop_count++;
		end
		pix_next = pop_now;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > `TIMEOUT_CYCLES)
			abort_run($sformatf("timeout, output not finished after %0d cycles",
				`TIMEOUT_CYCLES));
	end

	initial begin
		blk_we = 1'b0;
		blk_wr = '0;
		mcu_fmt = FMT_444;
		mcu_done = 1'b0;
		while (rst !== 1'b0)
			tick();

		check_ready("ycc_ready after reset", ycc_ready, 1'b1);
		check_ready("pix_valid after reset", pix_valid, 1'b0);

		load_mcu(FMT_444, SRC_RANDOM);
		queue_ref(FMT_444);
		pulse_done();
		wait_drained();

		load_mcu(FMT_420, SRC_RANDOM);
		queue_ref(FMT_420);
		pulse_done();
		wait_drained();

		// saturation
		load_mcu(FMT_420, SRC_EXTREME);
		queue_ref(FMT_420);
		pulse_done();
		wait_drained();

		// same mcu again under back-pressure
		load_mcu(FMT_420, SRC_RANDOM);
		queue_ref(FMT_420);
		pulse_done();
		wait_drained();
		load_mcu(FMT_420, SRC_REPLAY);
		queue_ref(FMT_420);
		bp_on = 1'b1;
		pulse_done();
		wait_drained();

		// B loads while A drains
		load_mcu(FMT_444, SRC_RANDOM);
		queue_ref(FMT_444);
		pulse_done();
		check_ready("ycc_ready while A drains", ycc_ready, 1'b1);
		base = pop_count;
		load_mcu(FMT_420, SRC_RANDOM);
		queue_ref(FMT_420);
		pulse_done();
		while (pop_count - base < 64) begin
			// fifo holds 2 so A's last step is still ahead
			if (pop_count - base <= 61)
				check_ready("ycc_ready before A ends", ycc_ready, 1'b0);
			tick();
		end
		check_ready("ycc_ready after A ends", ycc_ready, 1'b1);
		wait_drained();
		bp_on = 1'b0;

		repeat (4) tick();
		check_ready("pix_valid after last mcu", pix_valid, 1'b0);
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: build.f
+incdir+rtl
rtl/ycc_pkg.sv
rtl/mcu_out_fsm.sv
rtl/pix_counter.sv
rtl/ycc_pingpong_buf.sv
rtl/ycc_to_rgb.sv
rtl/pix_fifo.sv
rtl/ycc_rgb_top.sv
tests/tb_clk_gen.sv
tests/tb_ycc_rgb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ycc_rgb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_LINE ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_LINE"

# the run fails unless the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF -- '$(PASS_LINE)'

clean:
	rm -rf $(OBJ_DIR)
